// ==== source/coh_pkg.sv ====
// coherence controller sizes, bus message and memory command encodings, shared structs
package coh_pkg;

	// ------------------------------------------------------------------------
	// sizes
	localparam int unsigned LINE_W      = 6;             // 64 memory lines
	localparam int unsigned LINE_NUM    = 1 << LINE_W;
	localparam int unsigned DATA_W      = 64;
	localparam int unsigned MSHR_NUM    = 4;             // must stay a power of two
	localparam int unsigned MSHR_IDX_W  = 2;
	localparam int unsigned PTR_W       = 3;             // bus response queue pointer
	localparam int unsigned MEM_TAG_W   = 4;             // tag 0 means no accept
	localparam int unsigned MEM_LATENCY = 4;

	// ------------------------------------------------------------------------
	// encodings
	typedef enum logic [1:0] {
		MSG_NONE = 2'd0,
		GET_S    = 2'd1,
		GET_M    = 2'd2,
		PUT_M    = 2'd3
	} bus_msg_e;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_LOAD  = 2'd1,
		CMD_STORE = 2'd2
	} mem_cmd_e;

	// ------------------------------------------------------------------------
	// bus side
	typedef struct packed {
		bus_msg_e            msg;
		logic [LINE_W-1:0]   line;
		logic [DATA_W-1:0]   data;    // only meaningful for PUT_M
		logic [PTR_W-1:0]    ptr;
	} bus_req_t;

	// owner writeback seen on the bus
	typedef struct packed {
		logic                vld;
		logic [LINE_W-1:0]   line;
		logic [DATA_W-1:0]   data;
	} bus_fill_t;

	typedef struct packed {
		logic                vld;
		logic [PTR_W-1:0]    ptr;
		logic [DATA_W-1:0]   data;
	} ctrl_rsp_t;

	// ------------------------------------------------------------------------
	// queues and memory
	typedef struct packed {
		mem_cmd_e            cmd;
		logic                rdy;     // 0 while a store waits for fill data
		logic [LINE_W-1:0]   line;
		logic [DATA_W-1:0]   data;
		logic [PTR_W-1:0]    ptr;
	} iss_entry_t;

	typedef struct packed {
		mem_cmd_e            cmd;
		logic [LINE_W-1:0]   line;
		logic [DATA_W-1:0]   data;
	} mem_cmd_t;

	typedef struct packed {
		logic [MEM_TAG_W-1:0] tag;
		logic [DATA_W-1:0]    data;
	} mem_rsp_t;

	typedef struct packed {
		logic [MEM_TAG_W-1:0] tag;
		logic [PTR_W-1:0]     ptr;
	} rsp_entry_t;

endpackage

// ==== source/line_state_dir.sv ====
// line_state_dir: per-line valid/dirty directory, bus acknowledge, issue entry build
`timescale 1ns/1ps

module line_state_dir (
	input  logic                clk,
	input  logic                rst,
	input  coh_pkg::bus_req_t   bus_req_i,
	input  logic                iss_stall_i,
	output logic                ack_o,
	output logic                alloc_vld_o,
	output coh_pkg::iss_entry_t alloc_o
);
	import coh_pkg::*;

	// I = !vld, S = vld & !dty, M = dty
	logic [LINE_NUM-1:0] vld_r;
	logic [LINE_NUM-1:0] dty_r;
	logic [LINE_NUM-1:0] vld_nxt;
	logic [LINE_NUM-1:0] dty_nxt;
	logic                line_vld;
	logic                line_dty;

	assign line_vld = vld_r[bus_req_i.line];
	assign line_dty = dty_r[bus_req_i.line];

	// ------------------------------------------------------------------------
	// per message / state decision
	always_comb begin
		vld_nxt       = vld_r;
		dty_nxt       = dty_r;
		ack_o         = 1'b0;
		alloc_vld_o   = 1'b0;
		alloc_o.cmd   = CMD_NONE;
		alloc_o.rdy   = 1'b1;
		alloc_o.line  = bus_req_i.line;
		alloc_o.data  = bus_req_i.data;
		alloc_o.ptr   = bus_req_i.ptr;
		if (line_dty) begin
			// M, a cache owns the line
			if (bus_req_i.msg == PUT_M && !iss_stall_i) begin
				ack_o                    = 1'b1;
				alloc_vld_o              = 1'b1;
				alloc_o.cmd              = CMD_STORE;    // data rides with request
				vld_nxt[bus_req_i.line]  = 1'b0;
				dty_nxt[bus_req_i.line]  = 1'b0;
			end else if (bus_req_i.msg == GET_S && !iss_stall_i) begin
				ack_o                    = 1'b1;
				alloc_vld_o              = 1'b1;
				alloc_o.cmd              = CMD_STORE;
				alloc_o.rdy              = 1'b0;         // owner fill comes later
				dty_nxt[bus_req_i.line]  = 1'b0;
			end
		end else if (line_vld) begin
			// S, only GET_M is legal
			if (bus_req_i.msg == GET_M) begin
				ack_o                    = 1'b1;
				dty_nxt[bus_req_i.line]  = 1'b1;
			end
		end else begin
			if (bus_req_i.msg == GET_S && !iss_stall_i) begin
				ack_o                    = 1'b1;
				alloc_vld_o              = 1'b1;
				alloc_o.cmd              = CMD_LOAD;
				vld_nxt[bus_req_i.line]  = 1'b1;
			end else if (bus_req_i.msg == GET_M) begin
				ack_o                    = 1'b1;         // no queue needed
				vld_nxt[bus_req_i.line]  = 1'b1;
				dty_nxt[bus_req_i.line]  = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
			dty_r <= '0;
		end else begin
			vld_r <= vld_nxt;
			dty_r <= dty_nxt;
		end
	end

endmodule

// ==== source/mshr_issue_q.sv ====
// mshr_issue_q: circular queue of memory commands, bus fill capture, head issue
`timescale 1ns/1ps

module mshr_issue_q (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                alloc_vld_i,
	input  coh_pkg::iss_entry_t                 alloc_i,
	input  coh_pkg::bus_fill_t                  fill_i,
	input  logic                                rsp_stall_i,
	input  logic [coh_pkg::MEM_TAG_W-1:0]       mem_tag_i,
	output logic                                iss_stall_o,
	output coh_pkg::mem_cmd_t                   mem_cmd_o,
	output logic                                rsp_push_o,
	output coh_pkg::rsp_entry_t                 rsp_entry_o
);
	import coh_pkg::*;

	iss_entry_t            ent_r [MSHR_NUM];
	logic [MSHR_NUM-1:0]   vld_r;
	logic [MSHR_IDX_W:0]   head_r;       // msb is the wrap bit
	logic [MSHR_IDX_W:0]   tail_r;
	logic [MSHR_IDX_W-1:0] head_idx;
	logic [MSHR_IDX_W-1:0] tail_idx;
	iss_entry_t            head_ent;
	logic                  full;
	logic                  pop;

	assign head_idx = head_r[MSHR_IDX_W-1:0];
	assign tail_idx = tail_r[MSHR_IDX_W-1:0];
	assign head_ent = ent_r[head_idx];

	assign full        = (head_r[MSHR_IDX_W] != tail_r[MSHR_IDX_W]) && (head_idx == tail_idx);
	assign pop         = (mem_tag_i != '0);      // memory took the head
	assign iss_stall_o = full && !pop;

	// ------------------------------------------------------------------------
	// head issue to memory
	always_comb begin
		mem_cmd_o.cmd  = CMD_NONE;
		mem_cmd_o.line = head_ent.line;
		mem_cmd_o.data = head_ent.data;
		if (vld_r[head_idx] && head_ent.rdy) begin
			// loads also need room in the response queue
			if (!(head_ent.cmd == CMD_LOAD && rsp_stall_i))
				mem_cmd_o.cmd = head_ent.cmd;
		end
	end

	assign rsp_push_o      = pop && (mem_cmd_o.cmd == CMD_LOAD);
	assign rsp_entry_o.tag = mem_tag_i;
	assign rsp_entry_o.ptr = head_ent.ptr;

	// ------------------------------------------------------------------------
	// entry storage
	always_ff @(posedge clk) begin
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (fill_i.vld && vld_r[i] && !ent_r[i].rdy &&
			    ent_r[i].cmd == CMD_STORE && ent_r[i].line == fill_i.line) begin
				ent_r[i].data <= fill_i.data;   // owner writeback
				ent_r[i].rdy  <= 1'b1;
			end
		end
		if (alloc_vld_i)
			ent_r[tail_idx] <= alloc_i;
	end

	// pointers and valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r  <= '0;
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (pop) begin
				vld_r[head_idx] <= 1'b0;
				head_r          <= head_r + 1'b1;
			end
			// full with pop frees the slot the tail points at
			if (alloc_vld_i) begin
				vld_r[tail_idx] <= 1'b1;
				tail_r          <= tail_r + 1'b1;
			end
		end
	end

endmodule

// ==== source/mshr_rsp_q.sv ====
// mshr_rsp_q: in-order queue of accepted load tags and bus pointers, tag match and bus response
`timescale 1ns/1ps

module mshr_rsp_q (
	input  logic                clk,
	input  logic                rst,
	input  logic                push_i,
	input  coh_pkg::rsp_entry_t entry_i,
	input  coh_pkg::mem_rsp_t   mem_rsp_i,
	output logic                rsp_stall_o,
	output coh_pkg::ctrl_rsp_t  ctrl_rsp_o
);
	import coh_pkg::*;

	rsp_entry_t            ent_r [MSHR_NUM];
	logic [MSHR_IDX_W:0]   head_r;
	logic [MSHR_IDX_W:0]   tail_r;
	logic [MSHR_IDX_W-1:0] head_idx;
	logic                  full;
	logic                  empty;
	logic                  pop;

	assign head_idx = head_r[MSHR_IDX_W-1:0];
	assign full     = (head_r[MSHR_IDX_W] != tail_r[MSHR_IDX_W]) &&
	                  (head_idx == tail_r[MSHR_IDX_W-1:0]);
	assign empty    = (head_r == tail_r);

	// returning tag belongs to the oldest accepted load
	assign pop = !empty && (mem_rsp_i.tag != '0) && (mem_rsp_i.tag == ent_r[head_idx].tag);

	assign rsp_stall_o     = full && !pop;
	assign ctrl_rsp_o.vld  = pop;
	assign ctrl_rsp_o.ptr  = ent_r[head_idx].ptr;
	assign ctrl_rsp_o.data = mem_rsp_i.data;

	always_ff @(posedge clk) begin
		if (push_i)
			ent_r[tail_r[MSHR_IDX_W-1:0]] <= entry_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (pop)
				head_r <= head_r + 1'b1;
			if (push_i)
				tail_r <= tail_r + 1'b1;
		end
	end

endmodule

// ==== source/dmem_model.sv ====
// dmem_model: data memory array, accept tag counter, fixed-latency load return pipeline
`timescale 1ns/1ps

module dmem_model (
	input  logic                          clk,
	input  logic                          rst,
	input  coh_pkg::mem_cmd_t             mem_cmd_i,
	output logic [coh_pkg::MEM_TAG_W-1:0] mem_tag_o,
	output coh_pkg::mem_rsp_t             mem_rsp_o
);
	import coh_pkg::*;

	logic [DATA_W-1:0]    mem_r [LINE_NUM];
	logic [MEM_TAG_W-1:0] tag_cnt_r;
	mem_rsp_t             dly_r [MEM_LATENCY];
	logic                 accept;

	// every real command is taken in its own cycle
	assign accept    = (mem_cmd_i.cmd != CMD_NONE);
	assign mem_tag_o = accept ? tag_cnt_r : '0;
	assign mem_rsp_o = dly_r[MEM_LATENCY-1];

	// ------------------------------------------------------------------------
	// tag counter, 1..15
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_cnt_r <= MEM_TAG_W'(1);
		end else if (accept) begin
			if (tag_cnt_r == '1)
				tag_cnt_r <= MEM_TAG_W'(1);   // zero is reserved
			else
				tag_cnt_r <= tag_cnt_r + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// array, stores land at the accept edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LINE_NUM; i++)
				mem_r[i] <= '0;
		end else if (mem_cmd_i.cmd == CMD_STORE) begin
			mem_r[mem_cmd_i.line] <= mem_cmd_i.data;
		end
	end

	// load return pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_LATENCY; i++)
				dly_r[i] <= '0;
		end else begin
			if (mem_cmd_i.cmd == CMD_LOAD) begin
				dly_r[0].tag  <= tag_cnt_r;
				dly_r[0].data <= mem_r[mem_cmd_i.line];
			end else begin
				dly_r[0] <= '0;                   // empty slot, tag 0
			end
			for (int i = 1; i < MEM_LATENCY; i++)
				dly_r[i] <= dly_r[i-1];
		end
	end

endmodule

// ==== source/dmem_ctrl_top.sv ====
// dmem_ctrl_top: directory, issue queue, response queue and memory model wired together
`timescale 1ns/1ps

module dmem_ctrl_top (
	input  logic               clk,
	input  logic               rst,
	input  coh_pkg::bus_req_t  bus_req_i,
	input  coh_pkg::bus_fill_t bus_fill_i,
	output logic               ack_o,
	output coh_pkg::ctrl_rsp_t ctrl_rsp_o
);
	import coh_pkg::*;

	// directory -> issue queue
	logic                 alloc_vld;
	iss_entry_t           alloc;
	logic                 iss_stall;

	// issue queue <-> memory, response queue
	mem_cmd_t             mem_cmd;
	logic [MEM_TAG_W-1:0] mem_tag;
	mem_rsp_t             mem_rsp;
	logic                 rsp_push;
	rsp_entry_t           rsp_entry;
	logic                 rsp_stall;

	line_state_dir line_state_dir_i (
		.clk         (clk),
		.rst         (rst),
		.bus_req_i   (bus_req_i),
		.iss_stall_i (iss_stall),
		.ack_o       (ack_o),
		.alloc_vld_o (alloc_vld),
		.alloc_o     (alloc)
	);

	mshr_issue_q mshr_issue_q_i (
		.clk         (clk),
		.rst         (rst),
		.alloc_vld_i (alloc_vld),
		.alloc_i     (alloc),
		.fill_i      (bus_fill_i),
		.rsp_stall_i (rsp_stall),
		.mem_tag_i   (mem_tag),
		.iss_stall_o (iss_stall),
		.mem_cmd_o   (mem_cmd),
		.rsp_push_o  (rsp_push),
		.rsp_entry_o (rsp_entry)
	);

	mshr_rsp_q mshr_rsp_q_i (
		.clk         (clk),
		.rst         (rst),
		.push_i      (rsp_push),
		.entry_i     (rsp_entry),
		.mem_rsp_i   (mem_rsp),
		.rsp_stall_o (rsp_stall),
		.ctrl_rsp_o  (ctrl_rsp_o)
	);

	dmem_model dmem_model_i (
		.clk         (clk),
		.rst         (rst),
		.mem_cmd_i   (mem_cmd),
		.mem_tag_o   (mem_tag),
		.mem_rsp_o   (mem_rsp)
	);

endmodule

// ==== tb/tb_dmem_ctrl_ref.svh ====
// reference model of line states, memory contents and expected responses, compare tasks
`ifndef TB_DMEM_CTRL_REF_SVH
`define TB_DMEM_CTRL_REF_SVH

logic              ref_vld [LINE_NUM];
logic              ref_dty [LINE_NUM];
logic [DATA_W-1:0] ref_mem [LINE_NUM];     // stores applied in acknowledge order
ctrl_rsp_t         exp_q [$];              // expected responses, oldest first

task automatic ref_clear();
	for (int i = 0; i < LINE_NUM; i++) begin
		ref_vld[i] = 1'b0;
		ref_dty[i] = 1'b0;
		ref_mem[i] = '0;
	end
	exp_q.delete();
endtask

// legal for the line state, so acknowledged once the issue queue has room
function automatic logic dir_accepts(input bus_req_t req);
	logic vld;
	logic dty;
	vld = ref_vld[req.line];
	dty = ref_dty[req.line];
	case (req.msg)
		GET_S:   return !(vld && !dty);    // I or M
		GET_M:   return !dty;              // I or S
		PUT_M:   return dty;
		default: return 1'b0;
	endcase
endfunction

task automatic ref_apply(input bus_req_t req, input logic [DATA_W-1:0] fill_data);
	ctrl_rsp_t exp;
	case (req.msg)
		GET_S: begin
			if (ref_dty[req.line]) begin
				ref_mem[req.line] = fill_data;   // owner writeback lands in memory
				ref_dty[req.line] = 1'b0;
			end else begin
				exp.vld  = 1'b1;
				exp.ptr  = req.ptr;
				exp.data = ref_mem[req.line];
				exp_q.push_back(exp);
				ref_vld[req.line] = 1'b1;
			end
		end
		GET_M: begin
			ref_vld[req.line] = 1'b1;
			ref_dty[req.line] = 1'b1;
		end
		PUT_M: begin
			ref_mem[req.line] = req.data;
			ref_vld[req.line] = 1'b0;
			ref_dty[req.line] = 1'b0;
		end
		default: ;
	endcase
endtask

// ----------------------------------------------------------------------------
// compare tasks

task automatic check_ack(input logic got, input logic exp, input string what);
	if (got !== exp)
		report_error($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

task automatic check_rsp(input ctrl_rsp_t got, input ctrl_rsp_t exp);
	if (got.ptr !== exp.ptr || got.data !== exp.data)
		report_error($sformatf("response ptr %0d data %h, expected ptr %0d data %h",
		                       got.ptr, got.data, exp.ptr, exp.data));
endtask

task automatic check_mem_line(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input int line);
	if (got !== exp)
		report_error($sformatf("memory line %0d holds %h, expected %h", line, got, exp));
endtask

`endif

// ==== tb/tb_dmem_ctrl.sv ====
// testbench with clock, reset, directed and random bus requests, fill driver, response checker, watchdog
`timescale 1ns/1ps

module tb_dmem_ctrl;
	import coh_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int RST_CYCLES  = 8;
	localparam int N_RANDOM    = 200;
	localparam int N_REQ       = 25 + N_RANDOM;
	localparam int WDOG_CYCLES = RST_CYCLES + N_REQ * (MSHR_NUM + MEM_LATENCY + 4);

	logic      clk;
	logic      rst;
	bus_req_t  bus_req;
	bus_fill_t bus_fill;
	logic      ack;
	ctrl_rsp_t ctrl_rsp;

	int        cyc;
	int        seed;
	int        fill_due [$];     // cycle at which each pending fill goes out
	bus_fill_t fill_job [$];

	dmem_ctrl_top dmem_ctrl_top_i (
		.clk        (clk),
		.rst        (rst),
		.bus_req_i  (bus_req),
		.bus_fill_i (bus_fill),
		.ack_o      (ack),
		.ctrl_rsp_o (ctrl_rsp)
	);

	task automatic report_error(input string msg);
		$display("ERROR @%0t: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopped");
	endtask

	`include "tb_dmem_ctrl_ref.svh"

	// ------------------------------------------------------------------------
	// clock, cycle count, watchdog

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		cyc = 0;
		forever begin
			@(posedge clk);
			cyc = cyc + 1;
		end
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		report_failure("watchdog expired, the DUT stopped acknowledging or responding");
	end

	// owner fills go out one per cycle, oldest due first
	initial begin
		int        idx;
		bus_fill_t nxt;
		bus_fill = '0;
		forever begin
			@(posedge clk);
			#1;
			idx = -1;
			for (int i = 0; i < fill_due.size(); i++)
				if (idx < 0 && fill_due[i] <= cyc)
					idx = i;
			nxt = '0;
			if (idx >= 0) begin
				nxt = fill_job[idx];
				fill_due.delete(idx);
				fill_job.delete(idx);
			end
			bus_fill = nxt;
		end
	end

	// response checker samples mid-cycle
	initial begin
		ctrl_rsp_t exp;
		forever begin
			@(negedge clk);
			if (!rst && ctrl_rsp.vld === 1'b1) begin
				if (exp_q.size() == 0) begin
					report_error("response valid with no load outstanding");
				end else begin
					exp = exp_q.pop_front();
					check_rsp(ctrl_rsp, exp);
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// request driver starts and ends 1 ns after a rising edge

	task automatic send_req(input bus_msg_e msg, input int line, input logic [DATA_W-1:0] data,
	                        input logic [PTR_W-1:0] ptr, input logic [DATA_W-1:0] fill_data,
	                        input int fill_dly, output int held);
		bus_req_t  req;
		bus_fill_t job;
		logic      legal;
		logic      done;
		req.msg  = msg;
		req.line = LINE_W'(line);
		req.data = data;
		req.ptr  = ptr;
		legal    = dir_accepts(req);
		held     = 0;
		done     = 1'b0;
		bus_req  = req;
		while (!done) begin
			@(negedge clk);
			if (!legal || msg == GET_M) begin
				check_ack(ack, legal, $sformatf("ack for msg %0d on line %0d", msg, line));
				done = 1'b1;
			end else if (ack === 1'b1) begin
				done = 1'b1;
			end else begin
				held++;                          // issue queue full
			end
		end
		if (legal) begin
			if (msg == GET_S && ref_dty[req.line]) begin
				job.vld  = 1'b1;
				job.line = req.line;
				job.data = fill_data;
				fill_due.push_back(cyc + 1 + fill_dly);
				fill_job.push_back(job);
			end
			ref_apply(req, fill_data);
		end
		@(posedge clk);
		#1;
		bus_req = '0;
	endtask

	task automatic wait_drain(input int max_cyc);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cyc) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_q.size() != 0)
			report_failure($sformatf("%0d load responses never arrived", exp_q.size()));
	endtask

	// poll the memory array until the store has drained
	task automatic expect_mem_line(input int line, input logic [DATA_W-1:0] exp,
	                               input int max_cyc);
		logic [DATA_W-1:0] got;
		int                n;
		n   = 0;
		got = dmem_ctrl_top_i.dmem_model_i.mem_r[line];
		while (got !== exp && n < max_cyc) begin
			@(negedge clk);
			got = dmem_ctrl_top_i.dmem_model_i.mem_r[line];
			n++;
		end
		check_mem_line(got, exp, line);
		@(posedge clk);
		#1;
	endtask

	// ------------------------------------------------------------------------
	// test sequence

	initial begin
		int                held;
		int                held_sum;
		int                n;
		logic [31:0]       r;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] f;
		seed    = 32'h1aa0;
		rst     = 1'b1;
		bus_req = '0;
		ref_clear();
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// reset state, then a load of a fresh line
		@(negedge clk);
		check_ack(ack, 1'b0, "ack after reset");
		check_ack(ctrl_rsp.vld, 1'b0, "ctrl_rsp valid after reset");
		@(posedge clk);
		#1;
		send_req(GET_S, 5, '0, 3'd3, '0, 0, held);
		wait_drain(40);

		// PUT_M data comes back on a later GET_S
		send_req(GET_M, 10, '0, 3'd0, '0, 0, held);
		send_req(PUT_M, 10, 64'hdead_beef_0123_4567, 3'd0, '0, 0, held);
		send_req(GET_S, 10, '0, 3'd6, '0, 0, held);
		wait_drain(40);

		// GET_S on a modified line gets its data by fill
		send_req(GET_M, 12, '0, 3'd0, '0, 0, held);
		send_req(GET_S, 12, '0, 3'd2, 64'hf111_0000_c0de_0012, 5, held);
		if (held != 0)
			report_failure("GET_S on a modified line waited although the queue was empty");
		expect_mem_line(12, 64'hf111_0000_c0de_0012, 30);
		send_req(GET_M, 12, '0, 3'd0, '0, 0, held);
		send_req(PUT_M, 12, 64'h5a5a_1234_8765_a5a5, 3'd0, '0, 0, held);
		send_req(GET_S, 12, '0, 3'd4, '0, 0, held);
		wait_drain(40);

		// GET_M needs no response and illegal requests get no ack
		send_req(GET_M, 20, '0, 3'd0, '0, 0, held);
		send_req(GET_S, 21, '0, 3'd1, '0, 0, held);
		send_req(GET_M, 21, '0, 3'd0, '0, 0, held);    // shared line
		send_req(PUT_M, 22, 64'h1, 3'd0, '0, 0, held);  // invalid line
		send_req(GET_S, 23, '0, 3'd5, '0, 0, held);
		send_req(GET_S, 23, '0, 3'd7, '0, 0, held);     // shared line
		send_req(GET_M, 20, '0, 3'd0, '0, 0, held);     // already modified
		send_req(MSG_NONE, 24, '0, 3'd0, '0, 0, held);
		wait_drain(40);

		// burst behind a store that waits for its fill
		send_req(GET_M, 30, '0, 3'd0, '0, 0, held);
		send_req(GET_S, 30, '0, 3'd7, 64'h0bad_f00d_0000_0030, 24, held);
		held_sum = 0;
		for (int i = 0; i < 6; i++) begin
			send_req(GET_S, 40 + i, '0, PTR_W'(i), '0, 0, held);
			held_sum += held;
		end
		if (held_sum == 0)
			report_failure("burst never saw the issue queue hold a request back");
		wait_drain(80);

		// random mix over 8 lines
		for (int k = 0; k < N_RANDOM; k++) begin
			r = $random(seed);
			d = {$random(seed), $random(seed)};
			f = {$random(seed), $random(seed)};
			send_req(bus_msg_e'(r[1:0]), int'(r[4:2]), d, r[7:5], f, 3 + int'(r[10:8]), held);
		end

		// wait for the last loads to come back
		n = 0;
		while (exp_q.size() != 0 && n < 6 * (MSHR_NUM + MEM_LATENCY)) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("%0d load responses missing at end of run", exp_q.size());
			$display("Regression failed");
			$fatal(1, "responses missing");
		end
	end

endmodule

// ==== project.f ====
+incdir+tb
source/coh_pkg.sv
source/line_state_dir.sv
source/mshr_issue_q.sv
source/mshr_rsp_q.sv
source/dmem_model.sv
source/dmem_ctrl_top.sv
tb/tb_dmem_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dmem_ctrl \
	-f project.f -o Vtb_dmem_ctrl

sim_status=0
./obj_dir/Vtb_dmem_ctrl > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, exit status $sim_status"
	exit 1
fi
